// ==== common/cache_pkg.sv ====
package cache_pkg;

   // Word-addressed front end, so no byte offset bits in the address
   localparam int ADDR_W = 10;
   localparam int DATA_W = 32;
   localparam int NBYTES = DATA_W / 8;

   localparam int INDEX_W = 4; // 16 direct-mapped lines
   localparam int TAG_W = ADDR_W - INDEX_W;

   localparam int WTB_DEPTH_W = 2; // Write-through buffer holds 4 entries

   typedef logic [ADDR_W-1:0] word_addr_t;
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [NBYTES-1:0] strb_t; // All zero means a read
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [INDEX_W-1:0] index_t;

   // States of the second pipeline stage
   typedef enum logic [2:0] {
      IDLE,       // Waiting for a looked-up request
      CHECK,      // Answer cycle, ack is out to the requester
      DRAIN_WAIT, // Refill requested, older writes drain ahead of it
      REFILL,     // Refilled word goes into the line
      WBUF_PUSH   // Write waits for room in the buffer
   } resolve_state_t;

endpackage

// ==== common/mem_bus_if.sv ====
`timescale 1ns/100ps

// Native back-end bus, one transfer at a time
interface mem_bus_if;

   logic req; // One-cycle pulse per transfer
   logic ack; // Follows req by one cycle
   cache_pkg::word_addr_t addr;
   cache_pkg::word_t wdata;
   cache_pkg::strb_t wstrb;
   cache_pkg::word_t rdata; // Valid together with ack

   modport master (
      output req,
      output addr,
      output wdata,
      output wstrb,
      input  ack,
      input  rdata
   );

   modport slave (
      input  req,
      input  addr,
      input  wdata,
      input  wstrb,
      output ack,
      output rdata
   );

endinterface

// ==== cache/cache_lookup.sv ====
`timescale 1ns/100ps

module cache_lookup (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  req_i,
   input  cache_pkg::word_addr_t addr_i,
   input  cache_pkg::word_t      wdata_i,
   input  cache_pkg::strb_t      wstrb_i,
   input  logic                  busy_i,
   input  logic                  invalidate_i,
   input  logic                  fill_en_i,
   input  cache_pkg::index_t     fill_index_i,
   input  cache_pkg::tag_t       fill_tag_i,
   input  cache_pkg::word_t      fill_data_i,
   input  logic                  merge_en_i,
   input  cache_pkg::strb_t      merge_strb_i,
   input  cache_pkg::word_t      merge_data_i,
   output logic                  valid_o,
   output logic                  hit_o,
   output cache_pkg::word_t      line_data_o,
   output cache_pkg::word_addr_t addr_o,
   output cache_pkg::word_t      wdata_o,
   output cache_pkg::strb_t      wstrb_o,
   output logic                  invalidate_o
);

   logic [2**cache_pkg::INDEX_W-1:0] valid_bits;
   cache_pkg::tag_t tag_mem [2**cache_pkg::INDEX_W];
   cache_pkg::word_t data_mem [2**cache_pkg::INDEX_W];

   cache_pkg::index_t req_index;
   cache_pkg::tag_t req_tag;
   cache_pkg::index_t merge_index;
   logic accept;

   // A held request is taken once, the resolve stage keeps busy up until its ack is gone
   assign accept = req_i && !busy_i;

   assign req_index = addr_i[cache_pkg::INDEX_W-1:0];
   assign req_tag = addr_i[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W];

   // Write hits merge into the line of the request that is being resolved
   assign merge_index = addr_o[cache_pkg::INDEX_W-1:0];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_bits <= '0;
         valid_o <= 1'b0;
         invalidate_o <= 1'b0;
      end else begin
         valid_o <= accept;
         invalidate_o <= invalidate_i; // Passed on down the chain
         if (invalidate_i) begin
            valid_bits <= '0;
         end else if (fill_en_i) begin
            valid_bits[fill_index_i] <= 1'b1;
         end
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk_i) begin
      if (fill_en_i) begin
         tag_mem[fill_index_i] <= fill_tag_i;
         data_mem[fill_index_i] <= fill_data_i;
      end else if (merge_en_i) begin
         for (int b = 0; b < cache_pkg::NBYTES; b++) begin
            if (merge_strb_i[b]) begin
               data_mem[merge_index][8*b +: 8] <= merge_data_i[8*b +: 8];
            end
         end
      end
   end

   // Request and array read registered for the resolve stage
   always_ff @(posedge clk_i) begin
      if (accept) begin
         // An invalidate in the same cycle already counts as a miss
         hit_o <= valid_bits[req_index] && !invalidate_i && (tag_mem[req_index] == req_tag);
         line_data_o <= data_mem[req_index];
         addr_o <= addr_i;
         wdata_o <= wdata_i;
         wstrb_o <= wstrb_i;
      end
   end

endmodule

// ==== cache/cache_resolve.sv ====
`timescale 1ns/100ps

module cache_resolve (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  valid_i,
   input  logic                  hit_i,
   input  cache_pkg::word_t      line_data_i,
   input  cache_pkg::word_addr_t addr_i,
   input  cache_pkg::word_t      wdata_i,
   input  cache_pkg::strb_t      wstrb_i,
   output logic                  busy_o,
   output logic                  ack_o,
   output cache_pkg::word_t      rdata_o,
   output logic                  fill_en_o,
   output cache_pkg::index_t     fill_index_o,
   output cache_pkg::tag_t       fill_tag_o,
   output cache_pkg::word_t      fill_data_o,
   output logic                  merge_en_o,
   output cache_pkg::strb_t      merge_strb_o,
   output cache_pkg::word_t      merge_data_o,
   output logic                  push_o,
   input  logic                  full_i,
   output logic                  refill_req_o,
   output cache_pkg::word_addr_t refill_addr_o,
   input  logic                  refill_done_i,
   input  cache_pkg::word_t      refill_data_i
);

   cache_pkg::resolve_state_t state;
   cache_pkg::resolve_state_t state_nxt;
   cache_pkg::word_t refill_word;
   logic is_write;
   logic ack_set;

   assign is_write = |wstrb_i;

   // Covers the whole request, from lookup up to the ack cycle
   assign busy_o = valid_i || (state != cache_pkg::IDLE);

   assign merge_en_o = (state == cache_pkg::IDLE) && valid_i && hit_i && is_write;
   assign merge_strb_o = wstrb_i;
   assign merge_data_o = wdata_i;

   assign fill_en_o = (state == cache_pkg::REFILL);
   assign fill_index_o = addr_i[cache_pkg::INDEX_W-1:0];
   assign fill_tag_o = addr_i[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W];
   assign fill_data_o = refill_word;

   // The back end holds this off until its write buffer is empty
   assign refill_req_o = (state == cache_pkg::DRAIN_WAIT);
   assign refill_addr_o = addr_i;

   always_comb begin
      state_nxt = state;
      push_o = 1'b0;
      ack_set = 1'b0;
      case (state)
         cache_pkg::IDLE: begin
            if (valid_i) begin
               if (is_write) begin
                  // Hit or miss, every write goes through the buffer
                  if (!full_i) begin
                     push_o = 1'b1;
                     ack_set = 1'b1;
                     state_nxt = cache_pkg::CHECK;
                  end else begin
                     state_nxt = cache_pkg::WBUF_PUSH;
                  end
               end else if (hit_i) begin
                  ack_set = 1'b1;
                  state_nxt = cache_pkg::CHECK;
               end else begin
                  state_nxt = cache_pkg::DRAIN_WAIT;
               end
            end
         end
         cache_pkg::DRAIN_WAIT: begin
            if (refill_done_i) begin
               state_nxt = cache_pkg::REFILL;
            end
         end
         cache_pkg::REFILL: begin
            ack_set = 1'b1;
            state_nxt = cache_pkg::CHECK;
         end
         cache_pkg::WBUF_PUSH: begin
            if (!full_i) begin
               push_o = 1'b1;
               ack_set = 1'b1;
               state_nxt = cache_pkg::CHECK;
            end
         end
         cache_pkg::CHECK: begin
            state_nxt = cache_pkg::IDLE; // Requester sees ack and moves on
         end
         default: begin
            state_nxt = cache_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state <= cache_pkg::IDLE;
         ack_o <= 1'b0;
      end else begin
         state <= state_nxt;
         ack_o <= ack_set;
      end
   end

   always_ff @(posedge clk_i) begin
      if (refill_done_i) begin
         refill_word <= refill_data_i;
      end
      if (state == cache_pkg::REFILL) begin
         rdata_o <= refill_word;
      end else if ((state == cache_pkg::IDLE) && valid_i) begin
         rdata_o <= line_data_i; // Only read hits ack with this
      end
   end

endmodule

// ==== cache/backend_port.sv ====
`timescale 1ns/100ps

module backend_port (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  push_i,
   input  cache_pkg::word_addr_t push_addr_i,
   input  cache_pkg::word_t      push_data_i,
   input  cache_pkg::strb_t      push_strb_i,
   output logic                  full_o,
   input  logic                  wtb_empty_i,
   output logic                  wtb_empty_o,
   input  logic                  refill_req_i,
   input  cache_pkg::word_addr_t refill_addr_i,
   output logic                  refill_done_o,
   output cache_pkg::word_t      refill_data_o,
   mem_bus_if.master             bus
);

   cache_pkg::word_addr_t fifo_addr [2**cache_pkg::WTB_DEPTH_W];
   cache_pkg::word_t fifo_data [2**cache_pkg::WTB_DEPTH_W];
   cache_pkg::strb_t fifo_strb [2**cache_pkg::WTB_DEPTH_W];

   logic [cache_pkg::WTB_DEPTH_W-1:0] wr_ptr;
   logic [cache_pkg::WTB_DEPTH_W-1:0] rd_ptr;
   logic [cache_pkg::WTB_DEPTH_W:0] count;
   logic pending;     // A transfer is out on the bus
   logic pend_refill; // and it is a refill
   logic fifo_empty;
   logic issue_drain;
   logic issue_refill;

   assign fifo_empty = (count == '0);
   assign full_o = count[cache_pkg::WTB_DEPTH_W]; // Count equals the depth

   // Buffered writes always go first so a refill sees them in memory
   assign issue_drain = !pending && !fifo_empty;
   assign issue_refill = !pending && fifo_empty && refill_req_i;

   assign refill_done_o = bus.ack && pend_refill;
   assign refill_data_o = bus.rdata;

   // A drain in flight still counts as buffered data
   assign wtb_empty_o = wtb_empty_i && fifo_empty && !(pending && !pend_refill);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         pending <= 1'b0;
         pend_refill <= 1'b0;
         bus.req <= 1'b0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (issue_drain) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + {{cache_pkg::WTB_DEPTH_W{1'b0}}, push_i}
                        - {{cache_pkg::WTB_DEPTH_W{1'b0}}, issue_drain};
         bus.req <= issue_drain || issue_refill;
         if (issue_drain || issue_refill) begin
            pending <= 1'b1;
            pend_refill <= issue_refill;
         end else if (bus.ack) begin
            pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         fifo_addr[wr_ptr] <= push_addr_i;
         fifo_data[wr_ptr] <= push_data_i;
         fifo_strb[wr_ptr] <= push_strb_i;
      end
      if (issue_drain) begin
         bus.addr <= fifo_addr[rd_ptr];
         bus.wdata <= fifo_data[rd_ptr];
         bus.wstrb <= fifo_strb[rd_ptr];
      end else if (issue_refill) begin
         bus.addr <= refill_addr_i;
         bus.wstrb <= '0;
      end
   end

endmodule

// ==== source/backing_ram.sv ====
`timescale 1ns/100ps

module backing_ram (
   input  logic     clk_i,
   input  logic     rst_i,
   mem_bus_if.slave bus
);

   cache_pkg::word_t mem [2**cache_pkg::ADDR_W];

   // Memory starts out cleared
   initial begin
      for (int i = 0; i < 2**cache_pkg::ADDR_W; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (bus.req) begin
         for (int b = 0; b < cache_pkg::NBYTES; b++) begin
            if (bus.wstrb[b]) begin
               mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
         end
         bus.rdata <= mem[bus.addr]; // Only used when the strobe is zero
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.req;
      end
   end

endmodule

// ==== source/cache_sim_top.sv ====
`timescale 1ns/100ps

module cache_sim_top (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  req_i,
   input  cache_pkg::word_addr_t addr_i,
   input  cache_pkg::word_t      wdata_i,
   input  cache_pkg::strb_t      wstrb_i,
   output cache_pkg::word_t      rdata_o,
   output logic                  ack_o,
   input  logic                  invalidate_i,
   output logic                  invalidate_o,
   input  logic                  wtb_empty_i,
   output logic                  wtb_empty_o
);

   logic lk_valid;
   logic lk_hit;
   cache_pkg::word_t lk_line;
   cache_pkg::word_addr_t lk_addr;
   cache_pkg::word_t lk_wdata;
   cache_pkg::strb_t lk_wstrb;
   logic busy;
   logic fill_en;
   cache_pkg::index_t fill_index;
   cache_pkg::tag_t fill_tag;
   cache_pkg::word_t fill_data;
   logic merge_en;
   cache_pkg::strb_t merge_strb;
   cache_pkg::word_t merge_data;
   logic push;
   logic full;
   logic refill_req;
   cache_pkg::word_addr_t refill_addr;
   logic refill_done;
   cache_pkg::word_t refill_data;

   mem_bus_if u_bus ();

   cache_lookup u_lookup (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .busy_i       (busy),
      .invalidate_i (invalidate_i),
      .fill_en_i    (fill_en),
      .fill_index_i (fill_index),
      .fill_tag_i   (fill_tag),
      .fill_data_i  (fill_data),
      .merge_en_i   (merge_en),
      .merge_strb_i (merge_strb),
      .merge_data_i (merge_data),
      .valid_o      (lk_valid),
      .hit_o        (lk_hit),
      .line_data_o  (lk_line),
      .addr_o       (lk_addr),
      .wdata_o      (lk_wdata),
      .wstrb_o      (lk_wstrb),
      .invalidate_o (invalidate_o)
   );

   cache_resolve u_resolve (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .valid_i       (lk_valid),
      .hit_i         (lk_hit),
      .line_data_i   (lk_line),
      .addr_i        (lk_addr),
      .wdata_i       (lk_wdata),
      .wstrb_i       (lk_wstrb),
      .busy_o        (busy),
      .ack_o         (ack_o),
      .rdata_o       (rdata_o),
      .fill_en_o     (fill_en),
      .fill_index_o  (fill_index),
      .fill_tag_o    (fill_tag),
      .fill_data_o   (fill_data),
      .merge_en_o    (merge_en),
      .merge_strb_o  (merge_strb),
      .merge_data_o  (merge_data),
      .push_o        (push),
      .full_i        (full),
      .refill_req_o  (refill_req),
      .refill_addr_o (refill_addr),
      .refill_done_i (refill_done),
      .refill_data_i (refill_data)
   );

   // The buffer entry is the request held in the lookup stage
   backend_port u_backend (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .push_i        (push),
      .push_addr_i   (lk_addr),
      .push_data_i   (lk_wdata),
      .push_strb_i   (lk_wstrb),
      .full_o        (full),
      .wtb_empty_i   (wtb_empty_i),
      .wtb_empty_o   (wtb_empty_o),
      .refill_req_i  (refill_req),
      .refill_addr_i (refill_addr),
      .refill_done_o (refill_done),
      .refill_data_o (refill_data),
      .bus           (u_bus.master)
   );

   backing_ram u_ram (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .bus   (u_bus.slave)
   );

endmodule

// ==== verification/cache_checker.sv ====
`timescale 1ns/100ps

module cache_checker (
   input logic                  clk_i,
   input logic                  rst_i,
   input logic                  req_i,
   input cache_pkg::word_addr_t addr_i,
   input cache_pkg::strb_t      wstrb_i,
   input logic                  ack_o,
   input logic                  invalidate_i,
   input logic                  invalidate_o,
   input logic                  wtb_empty_i,
   input logic                  wtb_empty_o
);

   localparam int QUIET = 5 * (2**cache_pkg::WTB_DEPTH_W);

   int fail_count = 0;
   logic req_q;
   logic last_rd_valid; // Previous transaction was a read of last_rd_addr
   cache_pkg::word_addr_t last_rd_addr;
   logic inval_seen;
   int quiet_cnt;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         req_q <= 1'b0;
         last_rd_valid <= 1'b0;
         last_rd_addr <= '0;
         inval_seen <= 1'b0;
         quiet_cnt <= 0;
      end else begin
         req_q <= req_i;
         if (invalidate_i) begin
            last_rd_valid <= 1'b0;
         end else if (ack_o) begin
            last_rd_valid <= (wstrb_i == '0);
            last_rd_addr <= addr_i;
         end
         if (invalidate_i) begin
            inval_seen <= 1'b1;
         end else if (req_i && !req_q) begin
            inval_seen <= 1'b0; // A new request consumes the invalidate
         end
         if (req_i || !wtb_empty_i) begin
            quiet_cnt <= 0;
         end else if (quiet_cnt < QUIET) begin
            quiet_cnt <= quiet_cnt + 1;
         end
      end
   end

   assert property (@(posedge clk_i) rst_i |-> !ack_o)
      else begin fail_count++; $error("ack_o high during reset"); end

   assert property (@(posedge clk_i) disable iff (rst_i) ack_o |-> req_i)
      else begin fail_count++; $error("ack_o high without req_i"); end

   assert property (@(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o)
      else begin fail_count++; $error("ack_o high for two cycles"); end

   // Same read again right away must hit
   assert property (@(posedge clk_i) disable iff (rst_i)
      (req_i && !req_q && (wstrb_i == '0) && last_rd_valid && (addr_i == last_rd_addr))
      |-> ##1 !ack_o ##1 ack_o)
      else begin fail_count++; $error("repeated read did not ack after 2 cycles"); end

   assert property (@(posedge clk_i) disable iff (rst_i)
      (req_i && !req_q && (wstrb_i == '0) && inval_seen)
      |-> ##1 !ack_o ##1 !ack_o ##1 !ack_o)
      else begin fail_count++; $error("read after invalidate answered too early"); end

   assert property (@(posedge clk_i) disable iff (rst_i) invalidate_o == $past(invalidate_i))
      else begin fail_count++; $error("invalidate_o is not invalidate_i delayed"); end

   assert property (@(posedge clk_i) disable iff (rst_i) !wtb_empty_i |-> !wtb_empty_o)
      else begin fail_count++; $error("wtb_empty_o high while wtb_empty_i low"); end

   assert property (@(posedge clk_i) disable iff (rst_i)
      (ack_o && (wstrb_i != '0) && wtb_empty_i) |-> !wtb_empty_o)
      else begin fail_count++; $error("wtb_empty_o high after an acked write"); end

   assert property (@(posedge clk_i) disable iff (rst_i)
      ((quiet_cnt >= QUIET) && wtb_empty_i) |-> wtb_empty_o)
      else begin fail_count++; $error("wtb_empty_o low after a quiet period"); end

endmodule

bind cache_sim_top cache_checker u_checker (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .req_i        (req_i),
   .addr_i       (addr_i),
   .wstrb_i      (wstrb_i),
   .ack_o        (ack_o),
   .invalidate_i (invalidate_i),
   .invalidate_o (invalidate_o),
   .wtb_empty_i  (wtb_empty_i),
   .wtb_empty_o  (wtb_empty_o)
);

// ==== verification/cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb;

   localparam int N_RANDOM = 300;
   localparam int N_BURST = 12;
   localparam int N_TRANS = N_RANDOM + 2 * N_BURST + 16;
   localparam int LIMIT = 40 * N_TRANS + 200;
   localparam int QUIET = 5 * (2**cache_pkg::WTB_DEPTH_W);

   logic clk_i;
   logic rst_i;
   logic req_i;
   cache_pkg::word_addr_t addr_i;
   cache_pkg::word_t wdata_i;
   cache_pkg::strb_t wstrb_i;
   cache_pkg::word_t rdata_o;
   logic ack_o;
   logic invalidate_i;
   logic invalidate_o;
   logic wtb_empty_i;
   logic wtb_empty_o;

   logic [7:0] shadow [2**cache_pkg::ADDR_W][cache_pkg::NBYTES];
   int seed = 32'h0851_9955;
   int cycles = 0;
   int read_errors = 0;
   int reads_checked = 0;
   logic [31:0] rnd;
   cache_pkg::word_addr_t a;
   cache_pkg::word_t d;
   cache_pkg::strb_t s;
   cache_pkg::word_addr_t last_rd;
   logic last_was_read;

   cache_sim_top u_cache_sim_top (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .rdata_o      (rdata_o),
      .ack_o        (ack_o),
      .invalidate_i (invalidate_i),
      .invalidate_o (invalidate_o),
      .wtb_empty_i  (wtb_empty_i),
      .wtb_empty_o  (wtb_empty_o)
   );

   always #2 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", LIMIT);
         $display("Some tests failed");
         $finish;
      end
   end

   function automatic cache_pkg::word_t shadow_word(input cache_pkg::word_addr_t wa);
      cache_pkg::word_t w;
      for (int b = 0; b < cache_pkg::NBYTES; b++) begin
         w[8*b +: 8] = shadow[wa][b];
      end
      return w;
   endfunction

   // One request, held until ack, the caller is left at the ack edge
   task automatic access(input cache_pkg::word_addr_t ta, input cache_pkg::word_t td,
                         input cache_pkg::strb_t ts);
      cache_pkg::word_t got;
      cache_pkg::word_t exp;
      req_i <= 1'b1;
      addr_i <= ta;
      wdata_i <= td;
      wstrb_i <= ts;
      @(posedge clk_i);
      while (!ack_o) begin
         @(posedge clk_i);
      end
      got = rdata_o;
      if (ts == '0) begin
         exp = shadow_word(ta);
         reads_checked++;
         assert (got == exp) else begin
            read_errors++;
            $display("Error at %0d ns: read of %h returned %h, expected %h",
                     $time, ta, got, exp);
         end
      end else begin
         for (int b = 0; b < cache_pkg::NBYTES; b++) begin
            if (ts[b]) begin
               shadow[ta][b] = td[8*b +: 8];
            end
         end
      end
   endtask

   task automatic idle_cycle();
      req_i <= 1'b0;
      wstrb_i <= '0;
      @(posedge clk_i);
   endtask

   task automatic invalidate_cache();
      invalidate_i <= 1'b1;
      @(posedge clk_i);
      invalidate_i <= 1'b0;
      @(posedge clk_i);
   endtask

   initial begin
      for (int i = 0; i < 2**cache_pkg::ADDR_W; i++) begin
         for (int b = 0; b < cache_pkg::NBYTES; b++) begin
            shadow[i][b] = 8'h00; // Memory starts cleared too
         end
      end
      clk_i = 1'b0;
      rst_i = 1'b1;
      req_i = 1'b0;
      addr_i = '0;
      wdata_i = '0;
      wstrb_i = '0;
      invalidate_i = 1'b0;
      wtb_empty_i = 1'b1;
      last_rd = '0;
      last_was_read = 1'b0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      @(posedge clk_i);

      // Write, miss with drain first, hit, then a miss after invalidate
      access(10'h023, 32'hA5A5_1234, 4'hF);
      idle_cycle();
      access(10'h023, '0, '0);
      idle_cycle();
      access(10'h023, '0, '0);
      idle_cycle();
      invalidate_cache();
      access(10'h023, '0, '0);
      idle_cycle();

      for (int n = 0; n < N_RANDOM; n++) begin
         rnd = $random(seed);
         if (rnd[20:16] == 5'd0) begin
            invalidate_cache();
         end
         if (last_was_read && (rnd[15:13] == 3'd0)) begin
            a = last_rd;
            s = '0;
         end else begin
            a = {cache_pkg::tag_t'(rnd[1:0]), rnd[5:2]}; // Four tags share the lines
            if (rnd[8:6] < 3'd3) begin
               s = rnd[12:9];
               if (s == '0) begin
                  s = 4'hF;
               end
            end else begin
               s = '0;
            end
         end
         d = $random(seed);
         access(a, d, s);
         last_was_read = (s == '0);
         last_rd = a;
         idle_cycle();
      end

      // Back-to-back writes, then read every one of them back
      for (int i = 0; i < N_BURST; i++) begin
         d = $random(seed);
         access({cache_pkg::tag_t'(6'd9), cache_pkg::index_t'(i)}, d, 4'hF);
      end
      idle_cycle();
      for (int i = 0; i < N_BURST; i++) begin
         access({cache_pkg::tag_t'(6'd9), cache_pkg::index_t'(i)}, '0, '0);
         idle_cycle();
      end

      wtb_empty_i <= 1'b0; // Downstream not empty
      for (int i = 0; i < 3; i++) begin
         d = $random(seed);
         access({cache_pkg::tag_t'(6'd12), cache_pkg::index_t'(i)}, d, 4'h3);
         idle_cycle();
      end
      wtb_empty_i <= 1'b1;
      repeat (2 * QUIET) @(posedge clk_i);

      $display("Reads checked %0d, read errors %0d, checker errors %0d",
               reads_checked, read_errors, u_cache_sim_top.u_checker.fail_count);
      if ((read_errors == 0) && (u_cache_sim_top.u_checker.fail_count == 0)) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
common/cache_pkg.sv
common/mem_bus_if.sv
cache/cache_lookup.sv
cache/cache_resolve.sv
cache/backend_port.sv
source/backing_ram.sv
source/cache_sim_top.sv
verification/cache_checker.sv
verification/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
